// File: Bender.yml
package:
  name: obj_gfx

sources:
  - files:
      - verilog/obj_pkg.sv
      - verilog/obj_ram.sv
      - verilog/obj_scan.sv
      - verilog/obj_draw.sv
      - verilog/obj_line_buf.sv
      - verilog/obj_gfx.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/obj_gfx_tb.sv

// File: src.f
+incdir+tests
verilog/obj_pkg.sv
verilog/obj_ram.sv
verilog/obj_scan.sv
verilog/obj_draw.sv
verilog/obj_line_buf.sv
verilog/obj_gfx.sv
tests/obj_gfx_tb.sv

// File: tests/obj_gfx_model.svh
// Reference model of the sprite layer for the testbench
// Included in the testbench module, works from its table shadow and ROM image
`ifndef OBJ_GFX_MODEL_SVH
`define OBJ_GFX_MODEL_SVH

// Byte copy of the sprite table, updated on every CPU write
logic [7:0]  shadow [0:255];
// Graphics ROM image, 8 pixels per word
logic [31:0] rom_mem [0:8191];
// Line now being built, and the one being read out
obj_pxl_t    build_exp [0:255];
obj_pxl_t    read_exp [0:255];

// Expected sprite pixels for line vd
task automatic model_line(input logic [7:0] vd);
    logic [7:0]  ypos;
    logic [7:0]  xpos;
    logic [7:0]  code;
    logic [7:0]  attr;
    logic [7:0]  dy;
    logic [7:0]  x;
    logic [3:0]  p;
    logic [3:0]  pix;
    logic [63:0] row_gfx;
    for (int n = 0; n < 256; n++) begin
        build_exp[n] = '0;
    end
    // Index order, so lower entries land first
    for (int i = 0; i < OBJ_CNT_DEF; i++) begin
        ypos = shadow[i * 4];
        xpos = shadow[i * 4 + 1];
        code = shadow[i * 4 + 2];
        attr = shadow[i * 4 + 3];
        // Wrapping difference is the row
        dy = vd - ypos;
        if (dy < 8'd16) begin
            row_gfx = {rom_mem[{code, dy[3:0], 1'b1}], rom_mem[{code, dy[3:0], 1'b0}]};
            for (int s = 0; s < 16; s++) begin
                // Mirror picks pixels from the far end
                p   = attr[7] ? 4'(15 - s) : 4'(s);
                pix = row_gfx[p * 4 +: 4];
                x   = xpos + 8'(s);
                // Transparent never drawn, opaque never overwritten
                if (pix != 4'd0 && build_exp[x].pix == 4'd0) begin
                    build_exp[x].pal = attr[3:0];
                    build_exp[x].pix = pix;
                end
            end
        end
    end
endtask

`endif

// File: tests/obj_gfx_tb.sv
// Testbench for the sprite layer top level
// Random tables and ROM, every read out pixel compared with the model
`timescale 1ns/1ns
`default_nettype none

module obj_gfx_tb import obj_pkg::*; ();

    localparam int LINE_LEN  = 4096;
    // Warm up, single sprite lines, two table runs of 24 lines
    localparam int LINES_RUN = 2 + 5 + 2 * 24;
    localparam int LIMIT     = (LINES_RUN + 4) * LINE_LEN;

    logic        clk;
    logic        rst;
    logic        hs;
    logic        pxl_cen;
    logic [7:0]  vdump;
    logic [7:0]  hdump;
    logic        cpu_cs;
    logic        cpu_rnw;
    logic [7:0]  cpu_addr;
    logic [7:0]  cpu_dout;
    logic [7:0]  cpu_din;
    logic [12:0] rom_addr;
    logic        rom_cs;
    logic [31:0] rom_data = '0;
    logic        rom_ok = 1'b0;
    obj_pxl_t    col_addr;

    logic [31:0] lfsr_state = 32'h2e727560;
    logic [31:0] rsp_state = 32'h2e727560;
    logic [31:0] rsp_bits;
    logic        rom_busy = 1'b0;
    int          rom_wait = 0;
    logic        fixed_delay = 1'b0;
    int          lines_done = 0;
    int          cycles = 0;

    `include "obj_gfx_model.svh"

    obj_gfx #(.OBJ_CNT(64)) UUT (
        .clk      (clk),
        .rst      (rst),
        .hs       (hs),
        .pxl_cen  (pxl_cen),
        .vdump    (vdump),
        .hdump    (hdump),
        .cpu_cs   (cpu_cs),
        .cpu_rnw  (cpu_rnw),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .cpu_din  (cpu_din),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .col_addr (col_addr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int n, inout logic [31:0] st, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_next(st);
            v  = {v[30:0], st[0]};
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic cpu_write(input logic [7:0] a, input logic [7:0] d);
        cpu_cs    = 1'b1;
        cpu_rnw   = 1'b0;
        cpu_addr  = a;
        cpu_dout  = d;
        shadow[a] = d;
        @(negedge clk);
        cpu_cs  = 1'b0;
        cpu_rnw = 1'b1;
    endtask

    // Data shows up one edge after the address
    task automatic cpu_read(input logic [7:0] a, output logic [7:0] d);
        cpu_cs   = 1'b1;
        cpu_rnw  = 1'b1;
        cpu_addr = a;
        @(negedge clk);
        d      = cpu_din;
        cpu_cs = 1'b0;
    endtask

    task automatic place_sprite(input int idx, input logic [7:0] y, input logic [7:0] x,
                                input logic [7:0] code, input logic [7:0] attr);
        cpu_write(8'(idx * 4), y);
        cpu_write(8'(idx * 4 + 1), x);
        cpu_write(8'(idx * 4 + 2), code);
        cpu_write(8'(idx * 4 + 3), attr);
    endtask

    // Every sprite far below the lines under test
    task automatic park_table();
        for (int i = 0; i < 64; i++) begin
            place_sprite(i, 8'd200, 8'd0, 8'd0, 8'd0);
        end
    endtask

    // One full line, builds vd and reads out the previous build
    task automatic run_line(input logic [7:0] vd, input string name);
        for (int x = 0; x < 256; x++) begin
            read_exp[x] = build_exp[x];
        end
        model_line(vd);
        vdump = vd;
        hs    = 1'b1;
        @(negedge clk);
        hs = 1'b0;
        for (int h = 0; h < 256; h++) begin
            hdump   = h[7:0];
            pxl_cen = 1'b1;
            @(negedge clk);
            pxl_cen = 1'b0;
            // First two builds land in banks not yet erased
            if (lines_done >= 2) begin
                check_val($sformatf("%s x=%0d", name, h),
                          {24'd0, read_exp[h]}, {24'd0, col_addr});
            end
            repeat (7) @(negedge clk);
        end
        repeat (LINE_LEN - 1 - 256 * 8) @(negedge clk);
        lines_done++;
    endtask

    // Random table over 20 lines, then one sprite at rows 0, 15 and 16
    task automatic table_and_rows(input string name);
        logic [31:0] r;
        for (int a = 0; a < 256; a++) begin
            rand_bits(8, lfsr_state, r);
            cpu_write(a[7:0], r[7:0]);
        end
        for (int n = 0; n < 20; n++) begin
            rand_bits(8, lfsr_state, r);
            run_line(r[7:0], {name, "_table"});
        end
        park_table();
        rand_bits(24, lfsr_state, r);
        place_sprite(7, 8'd100, r[7:0], r[15:8], r[23:16]);
        run_line(8'd100, {name, "_row0"});
        run_line(8'd115, {name, "_row15"});
        run_line(8'd116, {name, "_row16"});
        run_line(8'd116, {name, "_row16_out"});
    endtask

    // ROM responder, holds rom_ok until cs drops
    always @(negedge clk) begin
        if (!rom_cs) begin
            rom_ok   = 1'b0;
            rom_busy = 1'b0;
        end else begin
            if (!rom_busy) begin
                rom_busy = 1'b1;
                if (fixed_delay) begin
                    rom_wait = 8;
                end else begin
                    rand_bits(4, rsp_state, rsp_bits);
                    rom_wait = rsp_bits % 9;
                end
            end
            if (rom_wait == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_mem[rom_addr];
            end else begin
                rom_wait = rom_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Run did not finish within %0d cycles", LIMIT);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] saved_seed;
        logic [7:0]  addrs [0:31];
        logic [7:0]  rd;
        rst      = 1'b1;
        hs       = 1'b0;
        pxl_cen  = 1'b0;
        vdump    = '0;
        hdump    = '0;
        cpu_cs   = 1'b0;
        cpu_rnw  = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        for (int a = 0; a < 8192; a++) begin
            rand_bits(32, lfsr_state, r);
            rom_mem[a] = r;
        end
        for (int n = 0; n < 256; n++) begin
            build_exp[n] = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // CPU write then read back
        for (int n = 0; n < 32; n++) begin
            rand_bits(16, lfsr_state, r);
            addrs[n] = r[15:8];
            cpu_write(r[15:8], r[7:0]);
        end
        for (int n = 0; n < 32; n++) begin
            cpu_read(addrs[n], rd);
            check_val("cpu_readback", {24'd0, shadow[addrs[n]]}, {24'd0, rd});
        end

        park_table();
        run_line(8'd50, "warm_up");
        run_line(8'd50, "warm_up");

        // Single sprite at row 5, plain then mirrored
        rand_bits(24, lfsr_state, r);
        place_sprite(0, 8'd45, r[7:0], r[15:8], {4'b0000, r[19:16]});
        run_line(8'd50, "single_plain");
        cpu_write(8'd3, {4'b1000, r[19:16]});
        run_line(8'd50, "single_flip");
        // Empty lines after readout show the erase
        park_table();
        run_line(8'd50, "single_flip_out");
        run_line(8'd50, "erase");
        run_line(8'd50, "erase");

        // Same table twice, random then slowest ROM
        saved_seed = lfsr_state;
        table_and_rows("random_delay");
        fixed_delay = 1'b1;
        lfsr_state  = saved_seed;
        table_and_rows("fixed_delay");

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/obj_draw.sv
// Draws one sprite row per request into the line buffer
// Two ROM words per row, then one pixel per cycle for 16 cycles
`timescale 1ns/1ns
`default_nettype none

module obj_draw import obj_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         hs,
    // From the scanner
    input  wire         draw_start,
    input  obj_req_t    draw_req,
    output logic        draw_busy,
    // Graphics ROM
    output logic        rom_cs,
    output logic [12:0] rom_addr,
    input  wire  [31:0] rom_data,
    input  wire         rom_ok,
    // Line buffer write side
    output logic        line_we,
    output logic [7:0]  line_addr,
    output obj_pxl_t    line_din
);

    draw_state_t state;
    logic [3:0]  step;
    obj_req_t    req;
    logic [63:0] gfx;
    logic [3:0]  pidx;
    logic [3:0]  pix;

    assign draw_busy = state != D_IDLE;

    // Half 0 is pixels 0 to 7, half 1 is pixels 8 to 15
    assign rom_addr = {req.code, req.row, state == D_FETCH1};

    // Mirror by walking the row backwards
    assign pidx = req.hflip ? ~step : step;
    assign pix  = gfx[{pidx, 2'b00} +: 4];

    // Transparent pixels never reach the buffer
    assign line_we       = state == D_PAINT && pix != 4'd0;
    assign line_addr     = req.xpos + {4'd0, step};
    assign line_din.pal  = req.pal;
    assign line_din.pix  = pix;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state  <= D_IDLE;
            step   <= '0;
            rom_cs <= 1'b0;
        end else if (hs) begin
            // Line over, drop whatever was in flight
            state  <= D_IDLE;
            rom_cs <= 1'b0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (draw_start) begin
                        state  <= D_FETCH0;
                        rom_cs <= 1'b1;
                    end
                end
                D_FETCH0: begin
                    if (rom_cs && rom_ok) begin
                        // Release cs for a cycle before the next word
                        state  <= D_FETCH1;
                        rom_cs <= 1'b0;
                    end
                end
                D_FETCH1: begin
                    if (!rom_cs) begin
                        rom_cs <= 1'b1;
                    end else if (rom_ok) begin
                        state  <= D_PAINT;
                        rom_cs <= 1'b0;
                        step   <= '0;
                    end
                end
                D_PAINT: begin
                    step <= step + 1'b1;
                    if (step == 4'(OBJ_SIZE - 1)) begin
                        state <= D_IDLE;
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    // Request and pixel data
    always_ff @(posedge clk) begin
        if (state == D_IDLE && draw_start) begin
            req <= draw_req;
        end
        if (state == D_FETCH0 && rom_cs && rom_ok) begin
            gfx[31:0] <= rom_data;
        end
        if (state == D_FETCH1 && rom_cs && rom_ok) begin
            gfx[63:32] <= rom_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/obj_gfx.sv
// Sprite layer top level
// Ties the table RAM, scanner, drawer and line buffer to CPU, ROM and video
`timescale 1ns/1ns
`default_nettype none

module obj_gfx import obj_pkg::*; #(
    parameter int OBJ_CNT = OBJ_CNT_DEF
) (
    input  wire                            clk,
    input  wire                            rst,
    // Video timing
    input  wire                            hs,
    input  wire                            pxl_cen,
    input  wire  [7:0]                     vdump,
    input  wire  [7:0]                     hdump,
    // CPU bus
    input  wire                            cpu_cs,
    input  wire                            cpu_rnw,
    input  wire  [$clog2(OBJ_CNT*4)-1:0]   cpu_addr,
    input  wire  [7:0]                     cpu_dout,
    output logic [7:0]                     cpu_din,
    // Graphics ROM
    output logic [12:0]                    rom_addr,
    output logic                           rom_cs,
    input  wire  [31:0]                    rom_data,
    input  wire                            rom_ok,
    // Pixel out, one line late
    output obj_pxl_t                       col_addr
);

    logic                          cpu_we;
    logic [$clog2(OBJ_CNT*4)-1:0]  scan_addr;
    logic [7:0]                    scan_dout;
    logic                          draw_start;
    logic                          draw_busy;
    obj_req_t                      draw_req;
    logic                          line_we;
    logic [7:0]                    line_addr;
    obj_pxl_t                      line_din;

    // Write strobe from the bus levels
    assign cpu_we = cpu_cs & ~cpu_rnw;

    obj_ram #(.OBJ_CNT(OBJ_CNT)) u_ram (
        .clk       (clk),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .cpu_din   (cpu_din),
        .scan_addr (scan_addr),
        .scan_dout (scan_dout)
    );

    obj_scan #(.OBJ_CNT(OBJ_CNT)) u_scan (
        .clk        (clk),
        .rst        (rst),
        .hs         (hs),
        .vdump      (vdump),
        .scan_addr  (scan_addr),
        .scan_dout  (scan_dout),
        .draw_busy  (draw_busy),
        .draw_start (draw_start),
        .draw_req   (draw_req)
    );

    obj_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .hs         (hs),
        .draw_start (draw_start),
        .draw_req   (draw_req),
        .draw_busy  (draw_busy),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .line_we    (line_we),
        .line_addr  (line_addr),
        .line_din   (line_din)
    );

    // Read side follows the beam, erasing as it goes
    obj_line_buf u_line (
        .clk     (clk),
        .rst     (rst),
        .hs      (hs),
        .we      (line_we),
        .wr_addr (line_addr),
        .wr_data (line_din),
        .rd_addr (hdump),
        .rd      (pxl_cen),
        .rd_data (col_addr)
    );

endmodule

`default_nettype wire

// File: verilog/obj_line_buf.sv
// Double line buffer for sprite pixels
// One bank is built while the other is read out and erased
`timescale 1ns/1ns
`default_nettype none

module obj_line_buf import obj_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        hs,
    // Drawer side
    input  wire        we,
    input  wire  [7:0] wr_addr,
    input  obj_pxl_t   wr_data,
    // Video side
    input  wire  [7:0] rd_addr,
    input  wire        rd,
    output obj_pxl_t   rd_data
);

    // Bank bit on top of the pixel column
    obj_pxl_t mem [0:511];
    logic     bank;
    obj_pxl_t old_pxl;

    // Whatever is already at the write spot
    assign old_pxl = mem[{bank, wr_addr}];

    // Swap roles at each line start
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bank <= 1'b0;
        end else if (hs) begin
            bank <= ~bank;
        end
    end

    always_ff @(posedge clk) begin
        // First opaque pixel wins, so lower table index is on top
        if (we && old_pxl.pix == 4'd0) begin
            mem[{bank, wr_addr}] <= wr_data;
        end
        // Erase behind the read, ready for the next build
        if (rd) begin
            mem[{~bank, rd_addr}] <= '0;
        end
    end

    // Read data holds between pxl_cen strobes
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rd) begin
            rd_data <= mem[{~bank, rd_addr}];
        end
    end

endmodule

`default_nettype wire

// File: verilog/obj_pkg.sv
// Types and constants shared by the sprite layer modules
// Every sprite module imports this package in its header
`default_nettype none

package obj_pkg;

    // Table size used when the top level does not override it
    localparam int OBJ_CNT_DEF = 64;
    // Sprites are square, 16 pixels each way
    localparam int OBJ_SIZE = 16;

    // One sprite table entry as stored in RAM
    // Byte 0 sits in the low bits, so declare from byte 3 down
    typedef struct packed {
        struct packed {
            logic       hflip;   // Horizontal mirror
            logic [2:0] unused;
            logic [3:0] pal;     // Palette select
        } attr;                  // Byte 3
        logic [7:0] code;        // Byte 2, sprite number
        logic [7:0] xpos;        // Byte 1
        logic [7:0] ypos;        // Byte 0
    } obj_entry_t;

    // Scanner to drawer request, one sprite row
    typedef struct packed {
        logic [7:0] code;
        logic [3:0] row;
        logic [7:0] xpos;
        logic [3:0] pal;
        logic       hflip;
    } obj_req_t;

    // Line buffer pixel
    // pix of zero is transparent
    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] pix;
    } obj_pxl_t;

    // Table walker states
    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_Y,
        S_RD_X,
        S_RD_CODE,
        S_RD_ATTR,
        S_WAIT_DRAW,
        S_NEXT
    } scan_state_t;

    // Row drawer states
    typedef enum logic [1:0] {
        D_IDLE,
        D_FETCH0,
        D_FETCH1,
        D_PAINT
    } draw_state_t;

endpackage

`default_nettype wire

// File: verilog/obj_ram.sv
// Sprite attribute table, 4 bytes per sprite
// CPU reads and writes one port, the scanner reads the other
`timescale 1ns/1ns
`default_nettype none

module obj_ram import obj_pkg::*; #(
    parameter int OBJ_CNT = OBJ_CNT_DEF
) (
    input  wire                            clk,
    // CPU side
    input  wire                            cpu_we,
    input  wire  [$clog2(OBJ_CNT*4)-1:0]   cpu_addr,
    input  wire  [7:0]                     cpu_dout,
    output logic [7:0]                     cpu_din,
    // Scanner side, read only
    input  wire  [$clog2(OBJ_CNT*4)-1:0]   scan_addr,
    output logic [7:0]                     scan_dout
);

    // Byte wide storage for the whole table
    logic [7:0] mem [0:OBJ_CNT*4-1];

    // CPU port
    // Read data shows up the cycle after the address
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_dout;
        end
        cpu_din <= mem[cpu_addr];
    end

    // Scanner port, registered like the CPU one
    always_ff @(posedge clk) begin
        scan_dout <= mem[scan_addr];
    end

endmodule

`default_nettype wire

// File: verilog/obj_scan.sv
// Walks the sprite table once per line, starting at hs
// Sprites that cover vdump are sent to the drawer in index order
`timescale 1ns/1ns
`default_nettype none

module obj_scan import obj_pkg::*; #(
    parameter int OBJ_CNT = OBJ_CNT_DEF
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            hs,
    input  wire  [7:0]                     vdump,
    // Table RAM read port
    output logic [$clog2(OBJ_CNT*4)-1:0]   scan_addr,
    input  wire  [7:0]                     scan_dout,
    // Drawer handoff
    input  wire                            draw_busy,
    output logic                           draw_start,
    output obj_req_t                       draw_req
);

    localparam int IDX_W = $clog2(OBJ_CNT);

    scan_state_t      state;
    logic [IDX_W-1:0] idx;
    logic [1:0]       sel;
    logic             last;
    logic [7:0]       dy;
    logic             in_range;
    obj_entry_t       ent;

    // Byte select follows the state
    // RAM data lands one state later
    always_comb begin
        case (state)
            S_RD_Y:    sel = 2'd0;
            S_RD_X:    sel = 2'd1;
            S_RD_CODE: sel = 2'd2;
            default:   sel = 2'd3;
        endcase
    end

    assign scan_addr = {idx, sel};
    assign last      = idx == IDX_W'(OBJ_CNT - 1);

    // Row within the sprite, wraps at 256
    assign dy       = vdump - ent.ypos;
    assign in_range = dy < 8'(OBJ_SIZE);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            idx        <= '0;
            draw_start <= 1'b0;
        end else begin
            draw_start <= 1'b0;
            if (hs) begin
                // New line, start over from entry 0
                state <= S_RD_Y;
                idx   <= '0;
            end else begin
                case (state)
                    S_RD_Y:    state <= S_RD_X;
                    S_RD_X:    state <= S_RD_CODE;
                    S_RD_CODE: state <= S_RD_ATTR;
                    S_RD_ATTR: state <= S_NEXT;
                    S_NEXT: begin
                        // Attr arrives now, ypos is already held
                        if (in_range) begin
                            state <= S_WAIT_DRAW;
                        end else begin
                            state <= last ? S_IDLE : S_RD_Y;
                            idx   <= idx + 1'b1;
                        end
                    end
                    S_WAIT_DRAW: begin
                        // Only one request outstanding at a time
                        if (!draw_busy) begin
                            draw_start <= 1'b1;
                            state      <= last ? S_IDLE : S_RD_Y;
                            idx        <= idx + 1'b1;
                        end
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // Entry assembly and request payload
    always_ff @(posedge clk) begin
        case (state)
            S_RD_X:    ent.ypos <= scan_dout;
            S_RD_CODE: ent.xpos <= scan_dout;
            S_RD_ATTR: ent.code <= scan_dout;
            S_NEXT:    ent.attr <= scan_dout;
            S_WAIT_DRAW: begin
                if (!draw_busy) begin
                    draw_req.code  <= ent.code;
                    draw_req.row   <= dy[3:0];
                    draw_req.xpos  <= ent.xpos;
                    draw_req.pal   <= ent.attr.pal;
                    draw_req.hflip <= ent.attr.hflip;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire
